// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsuTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard verilog/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation binary is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: tb.f
+incdir+tests
verilog/lsuPkg.sv
verilog/loadStoreBuffer.sv
verilog/dataMemory.sv
verilog/lsuTop.sv
tests/lsuTb.sv

// File: tests/lsuTasks.svh
`ifndef LSU_TASKS_SVH
`define LSU_TASKS_SVH

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
endfunction

// address inside the memory, aligned to the access size
function automatic lsuPkg::dataT randomAddr(input int bytes);
    lsuPkg::dataT a;
    a = xorshift32() & lsuPkg::dataT'(ModelBytes - 1);
    return a - (a % lsuPkg::dataT'(bytes));
endfunction

task automatic sendDispatch(input lsuPkg::memOpT op, input lsuPkg::nickT rd,
                            input lsuPkg::dataT imm,
                            input lsuPkg::nickT rs1Nick, input lsuPkg::dataT rs1Data,
                            input lsuPkg::nickT rs2Nick, input lsuPkg::dataT rs2Data);
    @(posedge clk);
    dispatch <= '{en: 1'b1, op: op, imm: imm, rd: rd, rs1Nick: rs1Nick, rs1Data: rs1Data,
                  rs2Nick: rs2Nick, rs2Data: rs2Data};
    @(posedge clk);
    dispatch.en <= 1'b0;
endtask

task automatic pulseCommit(input lsuPkg::nickT nick);
    @(posedge clk);
    commit     <= 1'b1;
    commitNick <= nick;
    @(posedge clk);
    commit <= 1'b0;
endtask

task automatic pulseExResult(input lsuPkg::nickT nick, input lsuPkg::dataT data);
    @(posedge clk);
    exResult <= '{en: 1'b1, nick: nick, data: data};
    @(posedge clk);
    exResult.en <= 1'b0;
endtask

task automatic storeAt(input lsuPkg::memOpT op, input lsuPkg::nickT slot,
                       input lsuPkg::dataT addr, input lsuPkg::dataT data, input bit doCommit);
    lsuPkg::dataT imm;
    imm = xorshift32() & 32'hfc;
    sendDispatch(op, slot, imm, '0, addr - imm, '0, data);
    if (doCommit) begin
        pulseCommit(slot);
        modelStore(op, addr, data);
    end
endtask

task automatic expectResult(input lsuPkg::nickT nick, input lsuPkg::dataT expected);
    int waited;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!loadResult.en && waited < ResultWait);
    assert (loadResult.en)
        else reportFailure($sformatf("no load result from slot %0d within %0d cycles",
                                     nick, ResultWait));
    assert (loadResult.nick == nick)
        else reportFailure($sformatf("mismatch loadResult.nick: got %h expected %h",
                                     loadResult.nick, nick));
    assert (loadResult.data == expected)
        else reportFailure($sformatf("mismatch loadResult.data: got %h expected %h",
                                     loadResult.data, expected));
endtask

task automatic expectQuiet(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        assert (!loadResult.en)
            else reportFailure($sformatf("unexpected load result from slot %0d",
                                         loadResult.nick));
    end
endtask

task automatic loadAndCheck(input lsuPkg::memOpT op, input lsuPkg::nickT slot,
                            input lsuPkg::dataT addr);
    lsuPkg::dataT imm;
    imm = xorshift32() & 32'hfc;
    sendDispatch(op, slot, imm, '0, addr - imm, '0, '0);
    expectResult(slot, modelLoad(op, addr));
endtask

task automatic testStoreLoadSizes();
    lsuPkg::memOpT storeOps [3];
    lsuPkg::dataT  addr;
    lsuPkg::dataT  data;
    storeOps[0] = lsuPkg::SB;
    storeOps[1] = lsuPkg::SH;
    storeOps[2] = lsuPkg::SW;
    // first round keeps top bits clear, second sets them
    for (int round = 0; round < 2; round++) begin
        for (int k = 0; k < 3; k++) begin
            addr = randomAddr(byteCount(storeOps[k]));
            data = xorshift32();
            data = (round == 0) ? (data & 32'h7f7f7f7f) : (data | 32'h80808080);
            storeAt(storeOps[k], 3'd1, addr, data, 1'b1);
            if (k == 0) begin
                loadAndCheck(lsuPkg::LB, 3'd2, addr);
                loadAndCheck(lsuPkg::LBU, 3'd2, addr);
            end else if (k == 1) begin
                loadAndCheck(lsuPkg::LH, 3'd2, addr);
                loadAndCheck(lsuPkg::LHU, 3'd2, addr);
            end
            // whole word shows which byte lanes were written
            loadAndCheck(lsuPkg::LW, 3'd2, addr & ~32'h3);
        end
    end
endtask

task automatic testExecuteWakeup();
    lsuPkg::dataT addr;
    lsuPkg::dataT imm;
    addr = randomAddr(4);
    storeAt(lsuPkg::SW, 3'd1, addr, xorshift32(), 1'b1);
    imm = xorshift32() & 32'hfc;
    sendDispatch(lsuPkg::LW, 3'd3, imm, 3'd4, '0, '0, '0);
    expectQuiet(12);
    pulseExResult(3'd4, addr - imm);
    expectResult(3'd3, modelLoad(lsuPkg::LW, addr));
endtask

task automatic testLoadWakeup();
    lsuPkg::dataT ptrAddr;
    lsuPkg::dataT tgtAddr;
    lsuPkg::dataT imm;
    ptrAddr = randomAddr(4);
    tgtAddr = ptrAddr ^ 32'h200;
    imm     = xorshift32() & 32'hfc;
    // first load returns a base, second load adds its imm to it
    storeAt(lsuPkg::SW, 3'd7, ptrAddr, tgtAddr - imm, 1'b1);
    storeAt(lsuPkg::SW, 3'd6, tgtAddr, xorshift32(), 1'b1);
    sendDispatch(lsuPkg::LW, 3'd2, 32'h0, '0, ptrAddr, '0, '0);
    sendDispatch(lsuPkg::LW, 3'd3, imm, 3'd2, '0, '0, '0);
    expectResult(3'd2, modelLoad(lsuPkg::LW, ptrAddr));
    expectResult(3'd3, modelLoad(lsuPkg::LW, tgtAddr));
endtask

task automatic testCommitOrder();
    lsuPkg::dataT addr;
    lsuPkg::dataT oldData;
    lsuPkg::dataT newData;
    addr    = randomAddr(4);
    oldData = xorshift32();
    newData = ~oldData;
    storeAt(lsuPkg::SW, 3'd1, addr, oldData, 1'b1);
    storeAt(lsuPkg::SW, 3'd5, addr, newData, 1'b0);
    loadAndCheck(lsuPkg::LW, 3'd2, addr);
    pulseCommit(3'd5);
    modelStore(lsuPkg::SW, addr, newData);
    loadAndCheck(lsuPkg::LW, 3'd2, addr);
endtask

task automatic testFullClear();
    // every load parks on tag 7 until it is broadcast
    for (int s = 1; s < 8; s++) begin
        @(negedge clk);
        assert (!full)
            else reportFailure($sformatf("mismatch full: got %h expected %h", full, 1'b0));
        sendDispatch(lsuPkg::LW, lsuPkg::nickT'(s), 32'h0, 3'd7, '0, '0, '0);
    end
    @(negedge clk);
    assert (full)
        else reportFailure($sformatf("mismatch full: got %h expected %h", full, 1'b1));
    // release all loads, then flush while the first one is inside the memory
    pulseExResult(3'd7, randomAddr(4));
    repeat (2) @(posedge clk);
    clr <= 1'b1;
    @(posedge clk);
    clr <= 1'b0;
    @(negedge clk);
    assert (!full)
        else reportFailure($sformatf("mismatch full: got %h expected %h", full, 1'b0));
    expectQuiet(20);
endtask

task automatic testIssueOrder();
    lsuPkg::dataT base;
    lsuPkg::dataT imm [3];
    base = randomAddr(4);
    for (int i = 0; i < 3; i++) begin
        imm[i] = 32'h10 * (i + 1);
    end
    storeAt(lsuPkg::SW, 3'd1, base + imm[0], xorshift32(), 1'b1);
    storeAt(lsuPkg::SW, 3'd2, base + imm[1], xorshift32(), 1'b1);
    storeAt(lsuPkg::SW, 3'd7, base + imm[2], xorshift32(), 1'b1);
    // dispatched out of slot order, all released by one broadcast
    sendDispatch(lsuPkg::LW, 3'd5, imm[0], 3'd4, '0, '0, '0);
    sendDispatch(lsuPkg::LW, 3'd3, imm[1], 3'd4, '0, '0, '0);
    sendDispatch(lsuPkg::LW, 3'd6, imm[2], 3'd4, '0, '0, '0);
    pulseExResult(3'd4, base);
    expectResult(3'd3, modelLoad(lsuPkg::LW, base + imm[1]));
    expectResult(3'd5, modelLoad(lsuPkg::LW, base + imm[0]));
    expectResult(3'd6, modelLoad(lsuPkg::LW, base + imm[2]));
endtask

`endif

// File: tests/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

    localparam int ClkPeriod     = 4;
    localparam int MemWords      = 256;
    localparam int MemLatency    = 2;
    localparam int ModelBytes    = MemWords * 4;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;
    localparam int ResultWait    = 40;

    logic             clk;
    logic             rstN;
    logic             clr;
    logic             commit;
    lsuPkg::nickT     commitNick;
    lsuPkg::dispatchT dispatch;
    lsuPkg::resultT   exResult;
    lsuPkg::resultT   loadResult;
    logic             full;

    logic [7:0]       refMem [ModelBytes];
    logic [31:0]      rngState = 32'hebd8;

    lsuTop #(
        .MemWords   (MemWords),
        .MemLatency (MemLatency)
    ) DUT (
        .clk        (clk),
        .rstN       (rstN),
        .clr        (clr),
        .dispatch   (dispatch),
        .exResult   (exResult),
        .commit     (commit),
        .commitNick (commitNick),
        .loadResult (loadResult),
        .full       (full)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(NumTests * CyclesPerTest * ClkPeriod);
        $display("timeout: tests did not finish within %0d cycles", NumTests * CyclesPerTest);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // reference memory, one byte per address, wraps like the DUT array
    function automatic int byteIndex(input lsuPkg::dataT addr, input int offset);
        return int'((addr + lsuPkg::dataT'(offset)) & lsuPkg::dataT'(ModelBytes - 1));
    endfunction

    function automatic int byteCount(input lsuPkg::memOpT op);
        if (op == lsuPkg::LB || op == lsuPkg::LBU || op == lsuPkg::SB) begin
            return 1;
        end
        if (op == lsuPkg::LH || op == lsuPkg::LHU || op == lsuPkg::SH) begin
            return 2;
        end
        return 4;
    endfunction

    function automatic void modelStore(input lsuPkg::memOpT op, input lsuPkg::dataT addr,
                                       input lsuPkg::dataT data);
        for (int i = 0; i < byteCount(op); i++) begin
            refMem[byteIndex(addr, i)] = data[8*i +: 8];
        end
    endfunction

    function automatic lsuPkg::dataT modelLoad(input lsuPkg::memOpT op, input lsuPkg::dataT addr);
        lsuPkg::dataT value;
        value = '0;
        for (int i = 0; i < byteCount(op); i++) begin
            value[8*i +: 8] = refMem[byteIndex(addr, i)];
        end
        // signed loads copy the top bit of the loaded size upward
        if (op == lsuPkg::LB && value[7]) begin
            value = value | 32'hffffff00;
        end
        if (op == lsuPkg::LH && value[15]) begin
            value = value | 32'hffff0000;
        end
        return value;
    endfunction

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    `include "lsuTasks.svh"

    initial begin
        for (int i = 0; i < ModelBytes; i++) begin
            refMem[i] = 8'h00;
        end
        rstN       = 1'b0;
        clr        = 1'b0;
        commit     = 1'b0;
        commitNick = '0;
        dispatch   = '0;
        exResult   = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        testStoreLoadSizes();
        testExecuteWakeup();
        testLoadWakeup();
        testCommitOrder();
        testFullClear();
        testIssueOrder();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int MemWords   = 256,
    parameter int MemLatency = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            clr,
    input  lsuPkg::memReqT  memReq,
    output logic            memReady,
    output lsuPkg::memRespT memResp
);

    localparam int IdxW = $clog2(MemWords);
    localparam int CntW = $clog2(MemLatency + 1);

    lsuPkg::dataT       mem [MemWords];
    lsuPkg::memReqT     req;
    logic               busy;
    logic [CntW-1:0]    count;
    logic               finish;
    logic [IdxW-1:0]    idx;
    logic [1:0]         lane;
    logic [3:0]         byteMask;
    lsuPkg::dataT       wordShifted, rawRead, loadData;

    assign memReady = !busy;
    assign finish   = busy && (count == '0);
    // word index wraps at the array size
    assign idx      = req.addr[IdxW+1:2];
    assign lane     = req.addr[1:0];

    always_comb begin
        case (req.len)
            lsuPkg::LenOne: byteMask = 4'b0001 << lane;
            lsuPkg::LenTwo: byteMask = 4'b0011 << lane;
            default:        byteMask = 4'b1111;
        endcase
        wordShifted = req.wdata << {lane, 3'b000};
        rawRead     = mem[idx] >> {lane, 3'b000};
        case (req.op)
            lsuPkg::LB:  loadData = {{24{rawRead[7]}}, rawRead[7:0]};
            lsuPkg::LBU: loadData = {24'd0, rawRead[7:0]};
            lsuPkg::LH:  loadData = {{16{rawRead[15]}}, rawRead[15:0]};
            lsuPkg::LHU: loadData = {16'd0, rawRead[15:0]};
            default:     loadData = rawRead;
        endcase
    end

    // held request
    always_ff @(posedge clk) begin
        if (memReq.en && !busy) begin
            req <= memReq;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy    <= 1'b0;
            count   <= '0;
            memResp <= '0;
        end else begin
            memResp.done <= 1'b0;
            if (clr) begin
                // in-flight request is dropped
                busy <= 1'b0;
            end else if (finish) begin
                busy          <= 1'b0;
                memResp.done  <= 1'b1;
                memResp.nick  <= req.nick;
                memResp.rdata <= req.isStore ? '0 : loadData;
            end else if (busy) begin
                count <= count - 1'b1;
            end else if (memReq.en) begin
                busy  <= 1'b1;
                count <= CntW'(MemLatency - 1);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < MemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (finish && req.isStore && !clr) begin
            for (int b = 0; b < 4; b++) begin
                if (byteMask[b]) begin
                    mem[idx][8*b +: 8] <= wordShifted[8*b +: 8];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        memReq.en |-> (memReq.len != lsuPkg::LenFour || memReq.addr[1:0] == 2'b00) &&
                      (memReq.len != lsuPkg::LenTwo || memReq.addr[0] == 1'b0))
        else $error("misaligned access at %h", memReq.addr);

endmodule

// File: verilog/loadStoreBuffer.sv
`timescale 1ns/1ps

module loadStoreBuffer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clr,
    input  lsuPkg::dispatchT dispatch,
    input  lsuPkg::resultT   exResult,
    input  lsuPkg::resultT   loadWake,
    output lsuPkg::resultT   loadResult,
    input  logic             commit,
    input  lsuPkg::nickT     commitNick,
    input  logic             memReady,
    output lsuPkg::memReqT   memReq,
    input  lsuPkg::memRespT  memResp,
    output logic             full
);

    localparam int NSlot = 1 << lsuPkg::NickW;

    logic [NSlot-1:0]   occupied, isStore, issued, committed;
    logic [NSlot-1:0]   rs1Ready, rs2Ready;
    lsuPkg::memOpT      op      [NSlot];
    lsuPkg::dataT       imm     [NSlot];
    lsuPkg::nickT       rs1Nick [NSlot];
    lsuPkg::nickT       rs2Nick [NSlot];
    lsuPkg::dataT       rs1Data [NSlot];
    lsuPkg::dataT       rs2Data [NSlot];

    logic [NSlot-1:0]   wake1, wake2;
    lsuPkg::dataT       wake1Data [NSlot];
    lsuPkg::dataT       wake2Data [NSlot];
    logic               dpRs1Ready, dpRs2Ready;
    lsuPkg::dataT       dpRs1Data, dpRs2Data;

    logic [NSlot-1:0]   storeCand, loadCand;
    logic               storeHit, loadHit, issueValid;
    lsuPkg::nickT       storeIdx, loadIdx, issueIdx;

    // tag 0 never matches, it means the operand came ready
    function automatic logic tagHit(input lsuPkg::resultT bus, input lsuPkg::nickT tag);
        return bus.en && (bus.nick == tag) && (tag != '0);
    endfunction

    function automatic lsuPkg::lenT lenOf(input lsuPkg::memOpT o);
        case (o)
            lsuPkg::LB, lsuPkg::LBU, lsuPkg::SB: return lsuPkg::LenOne;
            lsuPkg::LH, lsuPkg::LHU, lsuPkg::SH: return lsuPkg::LenTwo;
            default:                             return lsuPkg::LenFour;
        endcase
    endfunction

    function automatic logic isStoreOp(input lsuPkg::memOpT o);
        return (o == lsuPkg::SB) || (o == lsuPkg::SH) || (o == lsuPkg::SW);
    endfunction

    // wakeup from both broadcasts in the same cycle
    always_comb begin
        for (int i = 0; i < NSlot; i++) begin
            wake1[i] = occupied[i] && !rs1Ready[i] &&
                       (tagHit(exResult, rs1Nick[i]) || tagHit(loadWake, rs1Nick[i]));
            wake2[i] = occupied[i] && !rs2Ready[i] &&
                       (tagHit(exResult, rs2Nick[i]) || tagHit(loadWake, rs2Nick[i]));
            wake1Data[i] = tagHit(exResult, rs1Nick[i]) ? exResult.data : loadWake.data;
            wake2Data[i] = tagHit(exResult, rs2Nick[i]) ? exResult.data : loadWake.data;
        end
    end

    // operands may also be woken by a broadcast in the dispatch cycle
    always_comb begin
        dpRs1Ready = (dispatch.rs1Nick == '0) || tagHit(exResult, dispatch.rs1Nick) ||
                     tagHit(loadWake, dispatch.rs1Nick);
        dpRs2Ready = (dispatch.rs2Nick == '0) || tagHit(exResult, dispatch.rs2Nick) ||
                     tagHit(loadWake, dispatch.rs2Nick);
        if (tagHit(exResult, dispatch.rs1Nick)) begin
            dpRs1Data = exResult.data;
        end else if (tagHit(loadWake, dispatch.rs1Nick)) begin
            dpRs1Data = loadWake.data;
        end else begin
            dpRs1Data = dispatch.rs1Data;
        end
        if (tagHit(exResult, dispatch.rs2Nick)) begin
            dpRs2Data = exResult.data;
        end else if (tagHit(loadWake, dispatch.rs2Nick)) begin
            dpRs2Data = loadWake.data;
        end else begin
            dpRs2Data = dispatch.rs2Data;
        end
    end

    // committed store first, else lowest ready load
    always_comb begin
        storeCand = '0;
        loadCand  = '0;
        storeHit  = 1'b0;
        loadHit   = 1'b0;
        storeIdx  = '0;
        loadIdx   = '0;
        for (int i = NSlot - 1; i > 0; i--) begin
            storeCand[i] = occupied[i] && isStore[i] && committed[i] && !issued[i] &&
                           rs1Ready[i] && rs2Ready[i];
            loadCand[i]  = occupied[i] && !isStore[i] && !issued[i] && rs1Ready[i];
            if (storeCand[i]) begin
                storeHit = 1'b1;
                storeIdx = lsuPkg::nickT'(i);
            end
            if (loadCand[i]) begin
                loadHit = 1'b1;
                loadIdx = lsuPkg::nickT'(i);
            end
        end
        issueIdx   = storeHit ? storeIdx : loadIdx;
        // skip the cycle a request is on the bus, the memory drops ready after it
        issueValid = memReady && !memReq.en && (storeHit || loadHit);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupied  <= '0;
            issued    <= '0;
            committed <= '0;
            rs1Ready  <= '0;
            rs2Ready  <= '0;
        end else if (clr) begin
            occupied  <= '0;
            issued    <= '0;
            committed <= '0;
            rs1Ready  <= '0;
            rs2Ready  <= '0;
        end else begin
            rs1Ready <= rs1Ready | wake1;
            rs2Ready <= rs2Ready | wake2;
            if (commit) begin
                committed[commitNick] <= 1'b1;
            end
            if (issueValid) begin
                issued[issueIdx] <= 1'b1;
            end
            if (memResp.done) begin
                occupied[memResp.nick]  <= 1'b0;
                issued[memResp.nick]    <= 1'b0;
                committed[memResp.nick] <= 1'b0;
            end
            if (dispatch.en) begin
                occupied[dispatch.rd]  <= 1'b1;
                issued[dispatch.rd]    <= 1'b0;
                committed[dispatch.rd] <= 1'b0;
                rs1Ready[dispatch.rd]  <= dpRs1Ready;
                rs2Ready[dispatch.rd]  <= dpRs2Ready;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < NSlot; i++) begin
            if (wake1[i]) begin
                rs1Data[i] <= wake1Data[i];
            end
            if (wake2[i]) begin
                rs2Data[i] <= wake2Data[i];
            end
        end
        if (dispatch.en) begin
            op[dispatch.rd]      <= dispatch.op;
            imm[dispatch.rd]     <= dispatch.imm;
            isStore[dispatch.rd] <= isStoreOp(dispatch.op);
            rs1Nick[dispatch.rd] <= dispatch.rs1Nick;
            rs2Nick[dispatch.rd] <= dispatch.rs2Nick;
            rs1Data[dispatch.rd] <= dpRs1Data;
            rs2Data[dispatch.rd] <= dpRs2Data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memReq     <= '0;
            loadResult <= '0;
        end else if (clr) begin
            memReq     <= '0;
            loadResult <= '0;
        end else begin
            memReq.en <= issueValid;
            if (issueValid) begin
                memReq.isStore <= storeHit;
                memReq.nick    <= issueIdx;
                memReq.op      <= op[issueIdx];
                memReq.len     <= lenOf(op[issueIdx]);
                memReq.addr    <= rs1Data[issueIdx] + imm[issueIdx];
                memReq.wdata   <= storeHit ? rs2Data[issueIdx] : '0;
            end
            // stores complete silently
            loadResult.en <= memResp.done && !isStore[memResp.nick];
            if (memResp.done) begin
                loadResult.nick <= memResp.nick;
                loadResult.data <= memResp.rdata;
            end
        end
    end

    assign full = !clr && (&occupied[NSlot-1:1]);

    assert property (@(posedge clk) disable iff (!rstN || clr)
        dispatch.en |-> (dispatch.rd != '0) && !occupied[dispatch.rd])
        else $error("dispatch into occupied or reserved slot %0d", dispatch.rd);

    // request must meet an idle memory
    assert property (@(posedge clk) disable iff (!rstN || clr)
        memReq.en |-> memReady)
        else $error("memory request while memory busy");

    assert property (@(posedge clk) disable iff (!rstN || clr)
        commit |-> occupied[commitNick] && isStore[commitNick])
        else $error("commit names slot %0d, not a waiting store", commitNick);

endmodule

// File: verilog/lsuPkg.sv
package lsuPkg;

    // tag width gives 8 slots, slot 0 reserved for "operand ready"
    localparam int NickW = 3;
    localparam int DataW = 32;

    typedef logic [NickW-1:0] nickT;
    typedef logic [DataW-1:0] dataT;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LH  = 4'd2,
        LW  = 4'd3,
        LBU = 4'd4,
        LHU = 4'd5,
        SB  = 4'd6,
        SH  = 4'd7,
        SW  = 4'd8
    } memOpT;

    typedef enum logic [1:0] {
        LenOne  = 2'd0,
        LenTwo  = 2'd1,
        LenFour = 2'd2
    } lenT;

    // one load or store from dispatch
    typedef struct packed {
        logic  en;
        memOpT op;
        dataT  imm;
        nickT  rd;
        nickT  rs1Nick;
        dataT  rs1Data;
        nickT  rs2Nick;
        dataT  rs2Data;
    } dispatchT;

    // tag/data broadcast, used for execute and load results
    typedef struct packed {
        logic en;
        nickT nick;
        dataT data;
    } resultT;

    typedef struct packed {
        logic  en;
        logic  isStore;
        nickT  nick;
        memOpT op;
        lenT   len;
        dataT  addr;
        dataT  wdata;
    } memReqT;

    // rdata already extended for loads
    typedef struct packed {
        logic done;
        nickT nick;
        dataT rdata;
    } memRespT;

endpackage

// File: verilog/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
    parameter int MemWords   = 256,
    parameter int MemLatency = 2
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clr,
    input  lsuPkg::dispatchT dispatch,
    input  lsuPkg::resultT   exResult,
    input  logic             commit,
    input  lsuPkg::nickT     commitNick,
    output lsuPkg::resultT   loadResult,
    output logic             full
);

    lsuPkg::memReqT  memReq;
    lsuPkg::memRespT memResp;
    logic            memReady;

    // load results also wake waiting operands in the buffer
    loadStoreBuffer lsb (
        .clk        (clk),
        .rstN       (rstN),
        .clr        (clr),
        .dispatch   (dispatch),
        .exResult   (exResult),
        .loadWake   (loadResult),
        .loadResult (loadResult),
        .commit     (commit),
        .commitNick (commitNick),
        .memReady   (memReady),
        .memReq     (memReq),
        .memResp    (memResp),
        .full       (full)
    );

    dataMemory #(
        .MemWords   (MemWords),
        .MemLatency (MemLatency)
    ) dmem (
        .clk      (clk),
        .rstN     (rstN),
        .clr      (clr),
        .memReq   (memReq),
        .memReady (memReady),
        .memResp  (memResp)
    );

endmodule
